/* all.f */
+incdir+include
hdl/bk_pkg.sv
hdl/periph_bus_if.sv
hdl/bk_bus_ctrl.sv
hdl/sysreg_ctrl.sv
hdl/joy_mouse_port.sv
hdl/vector_irq_ctrl.sv
hdl/speaker_dac.sv
hdl/bk_periph_top.sv
tests/tb_bk_periph.sv

/* hdl/bk_bus_ctrl.sv */
// CPU bus glue and clock enable
`default_nettype none

`include "bk_defs.svh"

module bk_bus_ctrl (
	input  wire                   clk_sys,
	input  wire                   rst_i,
	input  wire                   turbo_i,
	input  wire bk_pkg::bus_word_t bus_addr_i,
	input  wire                   bus_stb_i,
	input  wire                   bus_we_i,
	input  wire [1:0]             bus_wtbt_i,
	input  wire                   bus_iack_i,
	input  wire bk_pkg::bus_word_t bus_din_i,
	output bk_pkg::bus_word_t     bus_dout_o,
	output logic                  bus_ack_o,
	output logic                  ce_cpu_o,
	periph_bus_if.host            pbus
);

	localparam logic [4:0] LAST_NORM  = 5'(`BK_CPU_DIV - 1);
	localparam logic [4:0] LAST_TURBO = 5'(`BK_CPU_DIV / 2 - 1);

	logic [4:0]        div_cnt;
	logic [4:0]        div_last;
	logic              turbo_q;
	logic              ce_q;
	bk_pkg::dev_sel_e  sel_d;
	logic              reply_d;
	bk_pkg::bus_word_t rd_or;
	logic              ack_q;
	bk_pkg::bus_word_t dout_q;

	////////////////////////////////////////////////////////////
	// Clock enable

	assign div_last = turbo_q ? LAST_TURBO : LAST_NORM;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			div_cnt <= '0;
			turbo_q <= 1'b0;
			ce_q    <= 1'b0;
		end else begin
			ce_q <= (div_cnt == '0);
			if (div_cnt == div_last) begin
				div_cnt <= '0;
				// Rate switch only between bus cycles
				if (!bus_stb_i)
					turbo_q <= turbo_i;
			end else begin
				div_cnt <= div_cnt + 5'd1;
			end
		end
	end

	assign ce_cpu_o = ce_q;

	////////////////////////////////////////////////////////////
	// Decode and reply

	always_comb begin
		if (bus_iack_i)
			sel_d = bus_we_i ? bk_pkg::DEV_NONE : bk_pkg::DEV_IVEC;
		else if (bus_addr_i == `BK_SYSREG_ADDR)
			sel_d = bk_pkg::DEV_SYSREG;
		else if (bus_addr_i == `BK_PORT_ADDR)
			sel_d = bk_pkg::DEV_PORT;
		else
			sel_d = bk_pkg::DEV_NONE;
	end

	assign pbus.sel   = sel_d;
	assign pbus.stb   = bus_stb_i;
	assign pbus.we    = bus_we_i;
	assign pbus.wtbt  = bus_wtbt_i;
	assign pbus.wdata = bus_din_i;

	// Registers answer at once, the vector unit when it has latched
	always_comb begin
		case (sel_d)
			bk_pkg::DEV_SYSREG, bk_pkg::DEV_PORT: reply_d = bus_stb_i;
			bk_pkg::DEV_IVEC:                     reply_d = bus_stb_i & pbus.ack_ivec;
			default:                              reply_d = 1'b0;
		endcase
	end

	assign rd_or = pbus.rdata_sys | pbus.rdata_port | pbus.rdata_ivec;

	always_ff @(posedge clk_sys) begin
		if (rst_i)
			ack_q <= 1'b0;
		else if (ce_q)
			ack_q <= reply_d;
	end

	// Read data held for the whole reply
	always_ff @(posedge clk_sys) begin
		if (ce_q && reply_d && !ack_q)
			dout_q <= rd_or;
	end

	assign bus_ack_o  = ack_q;
	assign bus_dout_o = dout_q;

	a_one_reader: assert property (@(posedge clk_sys) disable iff (rst_i)
		$onehot0({|pbus.rdata_sys, |pbus.rdata_port, |pbus.rdata_ivec}));

endmodule

`default_nettype wire

/* hdl/bk_periph_top.sv */
// BK0011M peripheral top level
`default_nettype none

module bk_periph_top (
	input  wire                    clk_sys,
	input  wire                    rst_i,
	input  wire                    turbo_i,
	input  wire bk_pkg::bus_word_t bus_addr_i,
	input  wire                    bus_stb_i,
	input  wire                    bus_we_i,
	input  wire [1:0]              bus_wtbt_i,
	input  wire                    bus_iack_i,
	input  wire bk_pkg::bus_word_t bus_din_i,
	output bk_pkg::bus_word_t      bus_dout_o,
	output logic                   bus_ack_o,
	output logic                   ce_cpu_o,
	input  wire                    key_down_i,
	input  wire                    key_stop_i,
	output logic                   cpu_irq1_o,
	input  wire [7:0]              joy0_i,
	input  wire [7:0]              joy1_i,
	input  wire [8:0]              mouse_dx_i,
	input  wire [8:0]              mouse_dy_i,
	input  wire                    mouse_upd_i,
	input  wire                    mouse_lbtn_i,
	input  wire                    mouse_rbtn_i,
	input  wire [1:0]              irq_req_i,
	output logic                   cpu_virq_o,
	output logic                   audio_o
);

	logic [2:0] spk;

	periph_bus_if pbus ();

	bk_bus_ctrl u_bus (
		.clk_sys, .rst_i, .turbo_i,
		.bus_addr_i, .bus_stb_i, .bus_we_i, .bus_wtbt_i, .bus_iack_i,
		.bus_din_i, .bus_dout_o, .bus_ack_o, .ce_cpu_o,
		.pbus(pbus.host)
	);

	sysreg_ctrl u_sysreg (
		.clk_sys, .rst_i, .pbus(pbus.sys_dev),
		.key_down_i, .key_stop_i, .cpu_irq1_o, .spk_o(spk)
	);

	joy_mouse_port u_port (
		.clk_sys, .rst_i, .pbus(pbus.port_dev),
		.joy0_i, .joy1_i, .mouse_dx_i, .mouse_dy_i,
		.mouse_upd_i, .mouse_lbtn_i, .mouse_rbtn_i
	);

	// Request 0 is vector 060, request 1 is vector 274
	vector_irq_ctrl #(.N_VEC(2)) u_ivec (
		.clk_sys, .rst_i, .pbus(pbus.ivec_dev), .irq_req_i, .cpu_virq_o
	);

	speaker_dac u_dac (
		.clk_sys, .rst_i, .spk_i(spk), .audio_o
	);

endmodule

`default_nettype wire

/* hdl/bk_pkg.sv */
// BK0011M peripheral types
`default_nettype none

`include "bk_defs.svh"

package bk_pkg;

	typedef logic [`BK_WORD_W-1:0] bus_word_t;

	// Device picked by the address decoder
	typedef enum logic [1:0] {
		DEV_NONE   = 2'd0,
		DEV_SYSREG = 2'd1,
		DEV_PORT   = 2'd2,
		DEV_IVEC   = 2'd3
	} dev_sel_e;

	// Mouse word as seen on the parallel port, bit 0 first at the bottom
	typedef struct packed {
		logic rbtn;
		logic lbtn;
		logic rsvd;
		logic left;
		logic down;
		logic right;
		logic up;
	} mouse_state_t;

endpackage

`default_nettype wire

/* hdl/joy_mouse_port.sv */
// Joystick and mouse parallel port
`default_nettype none

`include "bk_defs.svh"

module joy_mouse_port (
	input  wire            clk_sys,
	input  wire            rst_i,
	periph_bus_if.port_dev pbus,
	input  wire [7:0]      joy0_i,
	input  wire [7:0]      joy1_i,
	input  wire [8:0]      mouse_dx_i,
	input  wire [8:0]      mouse_dy_i,
	input  wire            mouse_upd_i,
	input  wire            mouse_lbtn_i,
	input  wire            mouse_rbtn_i
);

	localparam logic signed [8:0] THR = 9'(`BK_MOUSE_THRESH);

	logic                 wr;
	logic                 wr_q;
	logic                 mouse_mode;
	logic                 mouse_en;
	logic [7:0]           joy;
	logic signed [8:0]    dx_s;
	logic signed [8:0]    dy_s;
	bk_pkg::mouse_state_t ms_q;

	assign joy  = joy0_i | joy1_i;
	assign dx_s = mouse_dx_i;
	assign dy_s = mouse_dy_i;
	assign wr   = pbus.stb && pbus.we && pbus.wtbt[0] && (pbus.sel == bk_pkg::DEV_PORT);

	// Last active device wins
	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			mouse_mode <= 1'b0;
		end else begin
			if (|joy)
				mouse_mode <= 1'b0;
			if (mouse_upd_i)
				mouse_mode <= 1'b1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			wr_q     <= 1'b0;
			mouse_en <= 1'b0;
			ms_q     <= '0;
		end else begin
			wr_q      <= wr;
			ms_q.lbtn <= mouse_lbtn_i;
			ms_q.rbtn <= mouse_rbtn_i;
			if (wr && !wr_q) begin
				mouse_en <= pbus.wdata[3];
				if (!pbus.wdata[3])
					{ms_q.left, ms_q.down, ms_q.right, ms_q.up} <= 4'b0000;
			end else if (mouse_en && mouse_upd_i) begin
				// A direction sticks until software clears it
				if (!ms_q.up && !ms_q.down) begin
					if (dy_s > THR)  ms_q.up   <= 1'b1;
					if (dy_s < -THR) ms_q.down <= 1'b1;
				end
				if (!ms_q.right && !ms_q.left) begin
					if (dx_s > THR)  ms_q.right <= 1'b1;
					if (dx_s < -THR) ms_q.left  <= 1'b1;
				end
			end
		end
	end

	assign pbus.rdata_port = (pbus.sel != bk_pkg::DEV_PORT) ? '0 :
		mouse_mode ? {9'd0, ms_q} : {8'd0, joy};

	a_dir_excl: assert property (@(posedge clk_sys) disable iff (rst_i)
		!(ms_q.up && ms_q.down) && !(ms_q.left && ms_q.right));

endmodule

`default_nettype wire

/* hdl/periph_bus_if.sv */
// Internal peripheral bus
`default_nettype none

interface periph_bus_if;

	bk_pkg::dev_sel_e  sel;
	logic              stb;
	logic              we;
	logic [1:0]        wtbt;
	bk_pkg::bus_word_t wdata;
	bk_pkg::bus_word_t rdata_sys;
	bk_pkg::bus_word_t rdata_port;
	bk_pkg::bus_word_t rdata_ivec;
	logic              ack_ivec;

	modport host (
		output sel, stb, we, wtbt, wdata,
		input  rdata_sys, rdata_port, rdata_ivec, ack_ivec
	);

	modport sys_dev (
		input  sel, stb, we, wtbt, wdata,
		output rdata_sys
	);

	modport port_dev (
		input  sel, stb, we, wtbt, wdata,
		output rdata_port
	);

	// Vector reads carry no address or data
	modport ivec_dev (
		input  sel, stb,
		output rdata_ivec, ack_ivec
	);

endinterface

`default_nettype wire

/* hdl/speaker_dac.sv */
// Speaker sigma-delta DAC
`default_nettype none

`include "bk_defs.svh"

module speaker_dac (
	input  wire       clk_sys,
	input  wire       rst_i,
	input  wire [2:0] spk_i,
	output logic      audio_o
);

	localparam int W = `BK_DAC_W;

	logic [W-1:0] level;
	logic [W-1:0] acc_q;
	logic [W:0]   sum;
	logic         out_q;

	// Speaker bits as the top of the DAC word
	assign level = {spk_i, {(W - 3){1'b0}}};

	////////////////////////////////////////////////////////////
	// First-order modulator, carry out is the pulse stream

	assign sum = {1'b0, acc_q} + {1'b0, level};

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			acc_q <= '0;
			out_q <= 1'b0;
		end else begin
			acc_q <= sum[W-1:0];
			out_q <= sum[W];
		end
	end

	assign audio_o = out_q;

endmodule

`default_nettype wire

/* hdl/sysreg_ctrl.sv */
// System register at 177716
`default_nettype none

`include "bk_defs.svh"

module sysreg_ctrl (
	input  wire           clk_sys,
	input  wire           rst_i,
	periph_bus_if.sys_dev pbus,
	input  wire           key_down_i,
	input  wire           key_stop_i,
	output logic          cpu_irq1_o,
	output logic [2:0]    spk_o
);

	logic acc;
	logic acc_q;
	logic acc_rise;
	logic super_flg;
	logic stop_block;
	logic [2:0] spk_q;

	assign acc      = pbus.stb && (pbus.sel == bk_pkg::DEV_SYSREG);
	assign acc_rise = acc && !acc_q;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			acc_q      <= 1'b0;
			super_flg  <= 1'b0;
			stop_block <= 1'b0;
			spk_q      <= 3'b000;
		end else begin
			acc_q <= acc;
			if (acc_rise) begin
				super_flg <= pbus.we;
				if (pbus.we) begin
					// Bit 11 set in the high byte marks a STOP-block-free write
					if (pbus.wtbt[1] && !pbus.wdata[11])
						stop_block <= pbus.wdata[12];
					if (pbus.wtbt[0] && !(pbus.wtbt[1] && pbus.wdata[11]))
						spk_q <= {pbus.wdata[6], pbus.wdata[5], pbus.wdata[2]};
				end
			end
		end
	end

	// Start byte, fixed one, key state, supervisor flag
	assign pbus.rdata_sys = (pbus.sel == bk_pkg::DEV_SYSREG) ?
		{`BK_START_ADDR, 1'b1, ~key_down_i, 3'b000, super_flg, 2'b00} : '0;

	assign cpu_irq1_o = key_stop_i && !stop_block;
	assign spk_o      = spk_q;

endmodule

`default_nettype wire

/* hdl/vector_irq_ctrl.sv */
// Vectored interrupt controller
`default_nettype none

`include "bk_defs.svh"

module vector_irq_ctrl #(
	parameter int N_VEC = 2
) (
	input  wire             clk_sys,
	input  wire             rst_i,
	periph_bus_if.ivec_dev  pbus,
	input  wire [N_VEC-1:0] irq_req_i,
	output logic            cpu_virq_o
);

	localparam int IDX_W = (N_VEC > 1) ? $clog2(N_VEC) : 1;

	logic [N_VEC-1:0]  pend_q;
	logic [N_VEC-1:0]  clr_mask;
	logic [IDX_W-1:0]  hit_idx;
	logic              hit;
	logic              acc;
	logic              acc_q;
	logic              acc_rise;
	logic              ack_q;
	logic              virq_q;
	bk_pkg::bus_word_t vec_q;

	// Vector table, lowest index has priority
	function automatic bk_pkg::bus_word_t vec_of(input logic [IDX_W-1:0] idx);
		case (idx)
			IDX_W'(0): return `BK_IVEC_KBD;
			IDX_W'(1): return `BK_IVEC_AUX;
			default:   return '0;
		endcase
	endfunction

	always_comb begin
		hit     = 1'b0;
		hit_idx = '0;
		for (int i = N_VEC - 1; i >= 0; i--) begin
			if (pend_q[i]) begin
				hit     = 1'b1;
				hit_idx = IDX_W'(i);
			end
		end
	end

	assign acc      = pbus.stb && (pbus.sel == bk_pkg::DEV_IVEC);
	assign acc_rise = acc && !acc_q;
	assign clr_mask = (acc_rise && hit) ? (N_VEC'(1) << hit_idx) : '0;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			pend_q <= '0;
			acc_q  <= 1'b0;
			ack_q  <= 1'b0;
			virq_q <= 1'b0;
		end else begin
			acc_q  <= acc;
			virq_q <= |pend_q;
			// A new request wins over the clear in the same cycle
			pend_q <= (pend_q & ~clr_mask) | irq_req_i;
			if (acc_rise)
				ack_q <= 1'b1;
			else if (!acc)
				ack_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (acc_rise)
			vec_q <= hit ? vec_of(hit_idx) : '0;
	end

	assign pbus.rdata_ivec = (pbus.sel == bk_pkg::DEV_IVEC) ? vec_q : '0;
	assign pbus.ack_ivec   = ack_q;
	assign cpu_virq_o      = virq_q;

endmodule

`default_nettype wire

/* include/bk_defs.svh */
// BK0011M peripheral constants

`ifndef BK_DEFS_SVH
`define BK_DEFS_SVH

// Bus word width
`define BK_WORD_W       16

// Peripheral register addresses
`define BK_SYSREG_ADDR  16'o177716
`define BK_PORT_ADDR    16'o177714

// CPU enable period in clk_sys cycles, halved in turbo mode
`define BK_CPU_DIV      24

// High byte of the start address seen in the system register
`define BK_START_ADDR   8'o200

// Interrupt vectors
`define BK_IVEC_KBD     16'o000060
`define BK_IVEC_AUX     16'o000274

// Speaker DAC input width
`define BK_DAC_W        10

// Mouse motion needed to latch a direction
`define BK_MOUSE_THRESH 3

`endif

/* run_sim.sh */
#!/bin/sh
# Build and run the BK0011M peripheral testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_bk_periph -f all.f -o tb_bk_periph \
	|| { echo "build failed"; exit 1; }

out=$(./obj_dir/tb_bk_periph) || { echo "$out"; echo "simulation aborted"; exit 1; }
echo "$out"

# The run passes only if the testbench printed its pass line
echo "$out" | grep -qx "TB PASSED" && exit 0 || exit 1

/* tests/tb_bk_periph.sv */
// BK0011M peripheral testbench
`default_nettype none

`include "bk_defs.svh"

module tb_bk_periph;

	// Roughly ten times the length of all tests together
	localparam int TIMEOUT_CYC = 40000;
	localparam int ACK_WAIT    = 60;

	logic        clk_sys;
	logic        rst_i;
	logic        turbo;
	logic [15:0] bus_addr;
	logic        bus_stb;
	logic        bus_we;
	logic [1:0]  bus_wtbt;
	logic        bus_iack;
	logic [15:0] bus_din;
	logic [15:0] bus_dout;
	logic        bus_ack;
	logic        ce_cpu;
	logic        key_down;
	logic        key_stop;
	logic        cpu_irq1;
	logic [7:0]  joy0;
	logic [7:0]  joy1;
	logic [8:0]  mouse_dx;
	logic [8:0]  mouse_dy;
	logic        mouse_upd;
	logic        mouse_lbtn;
	logic        mouse_rbtn;
	logic [1:0]  irq_req;
	logic        cpu_virq;
	logic        audio;

	int seed      = 73;
	int n_checks  = 0;
	int n_err     = 0;
	int cycle_cnt = 0;

	bk_periph_top i_dut (
		.clk_sys(clk_sys), .rst_i(rst_i), .turbo_i(turbo),
		.bus_addr_i(bus_addr), .bus_stb_i(bus_stb), .bus_we_i(bus_we),
		.bus_wtbt_i(bus_wtbt), .bus_iack_i(bus_iack), .bus_din_i(bus_din),
		.bus_dout_o(bus_dout), .bus_ack_o(bus_ack), .ce_cpu_o(ce_cpu),
		.key_down_i(key_down), .key_stop_i(key_stop), .cpu_irq1_o(cpu_irq1),
		.joy0_i(joy0), .joy1_i(joy1), .mouse_dx_i(mouse_dx), .mouse_dy_i(mouse_dy),
		.mouse_upd_i(mouse_upd), .mouse_lbtn_i(mouse_lbtn), .mouse_rbtn_i(mouse_rbtn),
		.irq_req_i(irq_req), .cpu_virq_o(cpu_virq), .audio_o(audio)
	);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC) begin
			$display("Timeout: the run went past %0d cycles without finishing", TIMEOUT_CYC);
			$display("TB FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and expected values

	task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
			input string what);
		n_checks++;
		assert (got === exp) else begin
			$display("FAIL %0t: %s gave %o, expected %o", $time, what, got, exp);
			n_err++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		n_checks++;
		assert (got === exp) else begin
			$display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
			n_err++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		$display("test %-16s %0d errors", name, n_err - err_before);
	endtask

	// Start byte on top, bit 7 always set
	function automatic logic [15:0] sysreg_word(input logic kd, input logic sup);
		logic [15:0] w;
		w = {`BK_START_ADDR, 8'h80};
		if (!kd)
			w[6] = 1'b1;
		if (sup)
			w[2] = 1'b1;
		return w;
	endfunction

	function automatic logic [15:0] mouse_word(input logic up, right, down, left,
			lbtn, rbtn);
		logic [15:0] w;
		w = 16'h0000;
		w[0] = up;
		w[1] = right;
		w[2] = down;
		w[3] = left;
		w[5] = lbtn;
		w[6] = rbtn;
		return w;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus handshake

	task automatic wait_ack(input logic level, input string what);
		int n;
		n = 0;
		while (bus_ack !== level && n < ACK_WAIT) begin
			@(negedge clk_sys);
			n++;
		end
		n_checks++;
		assert (bus_ack === level) else begin
			$display("No reply: bus_ack_o did not go %b within %0d cycles during %s",
				level, ACK_WAIT, what);
			n_err++;
		end
	endtask

	task automatic bus_cycle(input logic [15:0] addr, input logic we,
			input logic [1:0] wtbt, input logic iack, input logic [15:0] din,
			input string what, output logic [15:0] dout);
		// Strobe lands on a CPU enable edge
		@(negedge clk_sys);
		while (!ce_cpu)
			@(negedge clk_sys);
		bus_addr = addr;
		bus_we   = we;
		bus_wtbt = wtbt;
		bus_iack = iack;
		bus_din  = din;
		bus_stb  = 1'b1;
		wait_ack(1'b1, what);
		dout     = bus_dout;
		bus_stb  = 1'b0;
		bus_we   = 1'b0;
		bus_wtbt = 2'b00;
		bus_iack = 1'b0;
		bus_addr = 16'h0000;
		bus_din  = 16'h0000;
		wait_ack(1'b0, what);
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [1:0] wtbt,
			input logic [15:0] data);
		logic [15:0] unused;
		bus_cycle(addr, 1'b1, wtbt, 1'b0, data, "write", unused);
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [15:0] data);
		bus_cycle(addr, 1'b0, 2'b00, 1'b0, 16'h0000, "read", data);
	endtask

	task automatic bus_iack_read(output logic [15:0] data);
		bus_cycle(16'h0000, 1'b0, 2'b00, 1'b1, 16'h0000, "interrupt acknowledge", data);
	endtask

	task automatic move_mouse(input logic [8:0] dx, input logic [8:0] dy);
		@(negedge clk_sys);
		mouse_dx  = dx;
		mouse_dy  = dy;
		mouse_upd = 1'b1;
		@(negedge clk_sys);
		mouse_upd = 1'b0;
		mouse_dx  = 9'd0;
		mouse_dy  = 9'd0;
	endtask

	task automatic measure_ce_gap(output int gap);
		@(negedge clk_sys);
		while (!ce_cpu)
			@(negedge clk_sys);
		@(negedge clk_sys);
		gap = 1;
		while (!ce_cpu) begin
			@(negedge clk_sys);
			gap++;
		end
	endtask

	task automatic check_dac(input logic [15:0] data);
		logic [9:0] lvl;
		int ones;
		int exp_ones;
		bus_write(`BK_SYSREG_ADDR, 2'b01, data);
		// Speaker bits 6, 5, 2 form the top of the level
		lvl      = {data[6], data[5], data[2], 7'd0};
		exp_ones = int'(lvl);
		repeat (16) @(negedge clk_sys);
		ones = 0;
		repeat (1024) begin
			@(negedge clk_sys);
			if (audio)
				ones++;
		end
		n_checks++;
		assert (ones >= exp_ones - 2 && ones <= exp_ones + 2) else begin
			$display("FAIL %0t: audio_o had %0d ones in 1024 cycles, expected %0d",
				$time, ones, exp_ones);
			n_err++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset();
		int err0;
		err0 = n_err;
		check_bit(bus_ack, 1'b0, "bus_ack_o after reset");
		check_bit(cpu_virq, 1'b0, "cpu_virq_o after reset");
		check_bit(cpu_irq1, 1'b0, "cpu_irq1_o after reset");
		check_bit(audio, 1'b0, "audio_o after reset");
		report_test("reset", err0);
	endtask

	task automatic test_sysreg();
		logic [15:0] rd;
		int err0;
		err0 = n_err;
		bus_read(`BK_SYSREG_ADDR, rd);
		check_word(rd, sysreg_word(1'b0, 1'b0), "system register read");
		bus_write(`BK_SYSREG_ADDR, 2'b01, 16'h0000);
		bus_read(`BK_SYSREG_ADDR, rd);
		check_word(rd, sysreg_word(1'b0, 1'b1), "system register after write");
		key_down = 1'b1;
		bus_read(`BK_SYSREG_ADDR, rd);
		check_word(rd, sysreg_word(1'b1, 1'b0), "system register with key down");
		key_down = 1'b0;
		report_test("system register", err0);
	endtask

	task automatic test_stop_spk();
		int err0;
		err0 = n_err;
		key_stop = 1'b1;
		bus_write(`BK_SYSREG_ADDR, 2'b10, 16'h1000);
		repeat (8) begin
			@(negedge clk_sys);
			check_bit(cpu_irq1, 1'b0, "cpu_irq1_o with STOP blocked");
		end
		bus_write(`BK_SYSREG_ADDR, 2'b10, 16'h0000);
		check_bit(cpu_irq1, 1'b1, "cpu_irq1_o with STOP released");
		key_stop = 1'b0;
		check_dac(16'h0064);
		check_dac(16'h0044);
		report_test("stop and speaker", err0);
	endtask

	task automatic test_joystick();
		logic [15:0] rd;
		int rnd;
		int err0;
		err0 = n_err;
		repeat (4) begin
			rnd  = $random(seed);
			joy0 = rnd[7:0];
			joy1 = rnd[15:8];
			if ((joy0 | joy1) == 8'h00)
				joy0 = 8'h01;
			bus_read(`BK_PORT_ADDR, rd);
			check_word(rd, {8'h00, joy0 | joy1}, "joystick port read");
		end
		joy0 = 8'h00;
		joy1 = 8'h00;
		report_test("joystick", err0);
	endtask

	task automatic test_mouse();
		logic [15:0] rd;
		int rnd;
		int err0;
		err0 = n_err;
		mouse_lbtn = 1'b1;
		bus_read(`BK_PORT_ADDR, rd);
		check_word(rd, 16'h0000, "port before mouse update");
		move_mouse(9'd0, 9'd0);
		bus_read(`BK_PORT_ADDR, rd);
		check_word(rd, mouse_word(0, 0, 0, 0, 1, 0), "port after mouse update");
		bus_write(`BK_PORT_ADDR, 2'b01, 16'h0008);
		move_mouse(9'd0, 9'd5);
		move_mouse(-9'sd6, 9'd0);
		// Opposite direction must not latch while up is held
		move_mouse(9'd0, -9'sd8);
		bus_read(`BK_PORT_ADDR, rd);
		check_word(rd, mouse_word(1, 0, 0, 1, 1, 0), "mouse directions");
		bus_write(`BK_PORT_ADDR, 2'b01, 16'h0000);
		bus_read(`BK_PORT_ADDR, rd);
		check_word(rd, mouse_word(0, 0, 0, 0, 1, 0), "mouse after clear");
		repeat (4) begin
			rnd        = $random(seed);
			mouse_lbtn = rnd[0];
			mouse_rbtn = rnd[1];
			bus_read(`BK_PORT_ADDR, rd);
			check_word(rd, mouse_word(0, 0, 0, 0, rnd[0], rnd[1]), "mouse buttons");
		end
		report_test("mouse", err0);
	endtask

	task automatic test_irq();
		logic [15:0] rd;
		int err0;
		err0 = n_err;
		@(negedge clk_sys);
		irq_req = 2'b11;
		@(negedge clk_sys);
		irq_req = 2'b00;
		repeat (2) @(negedge clk_sys);
		check_bit(cpu_virq, 1'b1, "cpu_virq_o with requests pending");
		bus_iack_read(rd);
		check_word(rd, 16'o000060, "first vector");
		bus_iack_read(rd);
		check_word(rd, 16'o000274, "second vector");
		repeat (3) @(negedge clk_sys);
		check_bit(cpu_virq, 1'b0, "cpu_virq_o after both vectors");
		report_test("interrupts", err0);
	endtask

	task automatic test_clock_enable();
		int gap;
		int err0;
		err0 = n_err;
		measure_ce_gap(gap);
		check_word(16'(gap), 16'(`BK_CPU_DIV), "normal CPU enable period");
		turbo = 1'b1;
		// Rate switches at the next divider wrap
		measure_ce_gap(gap);
		measure_ce_gap(gap);
		measure_ce_gap(gap);
		check_word(16'(gap), 16'(`BK_CPU_DIV / 2), "turbo CPU enable period");
		turbo = 1'b0;
		report_test("clock enable", err0);
	endtask

	initial begin
		rst_i      = 1'b1;
		turbo      = 1'b0;
		bus_addr   = 16'h0000;
		bus_stb    = 1'b0;
		bus_we     = 1'b0;
		bus_wtbt   = 2'b00;
		bus_iack   = 1'b0;
		bus_din    = 16'h0000;
		key_down   = 1'b0;
		key_stop   = 1'b0;
		joy0       = 8'h00;
		joy1       = 8'h00;
		mouse_dx   = 9'd0;
		mouse_dy   = 9'd0;
		mouse_upd  = 1'b0;
		mouse_lbtn = 1'b0;
		mouse_rbtn = 1'b0;
		irq_req    = 2'b00;
		repeat (8) @(negedge clk_sys);
		rst_i = 1'b0;

		test_reset();
		test_sysreg();
		test_stop_spk();
		test_joystick();
		test_mouse();
		test_irq();
		test_clock_enable();

		$display("checks run: %0d, errors: %0d", n_checks, n_err);
		if (n_err == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
